//--- microrocPkg.sv
package microrocPkg;

   //////////////////////////////////////////////////
   // Widths fixed by the ASIC
   typedef logic [15:0] srWordT;    // Serial register word, MSB first
   typedef logic [2:0]  chipCntT;   // Chips in the chain, 0 counts as 1
   typedef logic [5:0]  chnT;       // Probed channel index
   typedef logic [15:0] acqTimeT;   // START_ACQ length in Clk cycles
   typedef logic [15:0] ramWordT;   // Parallel RAM readout word

   //////////////////////////////////////////////////
   // Frame and timing constants
   localparam int SC_WORDS      = 4;   // 64-bit slow-control image per chip
   localparam int RR_WORDS      = 4;   // 64 channels, one-hot
   localparam int PWR_SETTLE    = 4;   // Power-on to START_ACQ
   localparam int SR_RST_CYCLES = 2;   // SR_RSTB low time before a frame

   //////////////////////////////////////////////////
   // State machines
   typedef enum logic [2:0] {
      daqIdle,
      daqPowerUp,
      daqAcquire,
      daqReadout,
      daqPowerDown
   } daqStateT;

   typedef enum logic [1:0] {
      srIdle,
      srRegReset,
      srShift,
      srAck
   } srStateT;

endpackage

//--- srBusIf.sv
`timescale 1ns/10ps

interface srBusIf;
   logic                req;     // Word request, four-phase
   logic                ack;     // Word fully shifted
   logic                sel;     // 1 slow control, 0 read register
   logic                first;   // First word of a frame
   microrocPkg::srWordT data;    // Word to shift, MSB first

   modport client (
      output req,
      output sel,
      output first,
      output data,
      input  ack
   );

   modport server (
      input  req,
      input  sel,
      input  first,
      input  data,
      output ack
   );
endinterface

//--- scLoader.sv
`timescale 1ns/10ps

module scLoader (
   input  logic                 Clk,
   input  logic                 rstN,
   input  logic                 startLoad,
   input  microrocPkg::chipCntT asicNum,
   input  logic [63:0]          scConfig,
   output logic                 configDone,
   srBusIf.client               bus
);
   logic                 busy;       // Frame in progress
   logic                 lastWord;   // Final word of the chain acked
   logic [1:0]           wordIdx;    // Word within one chip image
   microrocPkg::chipCntT chipIdx;    // Chip being loaded
   microrocPkg::chipCntT lastChip;

   assign lastChip = (asicNum == '0) ? '0 : asicNum - 3'd1;   // Zero chips read as one
   assign bus.sel  = 1'b1;                                     // Slow-control register
   assign bus.data = scConfig[(microrocPkg::SC_WORDS - 1 - wordIdx) * 16 +: 16];   // MSB word first

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         busy       <= 1'b0;
         lastWord   <= 1'b0;
         wordIdx    <= '0;
         chipIdx    <= '0;
         configDone <= 1'b0;
         bus.req    <= 1'b0;
         bus.first  <= 1'b0;
      end else if (startLoad && !busy) begin
         busy       <= 1'b1;
         lastWord   <= 1'b0;
         wordIdx    <= '0;
         chipIdx    <= '0;
         configDone <= 1'b0;             // Cleared for the new load
         bus.req    <= 1'b1;
         bus.first  <= 1'b1;             // Only the very first word
      end else if (busy) begin
         if (bus.req && bus.ack) begin   // Phase 3, drop req
            bus.req   <= 1'b0;
            bus.first <= 1'b0;
            if (wordIdx == 2'(microrocPkg::SC_WORDS - 1)) begin
               wordIdx <= '0;
               if (chipIdx == lastChip) begin
                  lastWord <= 1'b1;
               end else begin
                  chipIdx <= chipIdx + 3'd1;
               end
            end else begin
               wordIdx <= wordIdx + 2'd1;
            end
         end else if (!bus.req && !bus.ack) begin   // Ack has fallen
            if (lastWord) begin
               busy       <= 1'b0;
               configDone <= 1'b1;
            end else begin
               bus.req <= 1'b1;          // Re-raise at once to keep the grant
            end
         end
      end
   end

endmodule

//--- rrLoader.sv
`timescale 1ns/10ps

module rrLoader (
   input  logic                 Clk,
   input  logic                 rstN,
   input  logic                 startRead,
   input  microrocPkg::chipCntT asicNum,
   input  microrocPkg::chnT     probeChn,
   srBusIf.client               bus
);
   logic                 busy;
   logic                 lastWord;
   logic [1:0]           wordIdx;
   microrocPkg::chipCntT chipIdx;
   microrocPkg::chipCntT lastChip;
   logic [63:0]          image;      // One-hot channel image

   assign image    = 64'(1) << probeChn;
   assign lastChip = (asicNum == '0) ? '0 : asicNum - 3'd1;
   assign bus.sel  = 1'b0;           // Read register
   assign bus.data = image[(microrocPkg::RR_WORDS - 1 - wordIdx) * 16 +: 16];

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         busy      <= 1'b0;
         lastWord  <= 1'b0;
         wordIdx   <= '0;
         chipIdx   <= '0;
         bus.req   <= 1'b0;
         bus.first <= 1'b0;
      end else if (startRead && !busy) begin
         busy      <= 1'b1;
         lastWord  <= 1'b0;
         wordIdx   <= '0;
         chipIdx   <= '0;
         bus.req   <= 1'b1;
         bus.first <= 1'b1;
      end else if (busy) begin
         if (bus.req && bus.ack) begin
            bus.req   <= 1'b0;
            bus.first <= 1'b0;
            if (wordIdx == 2'(microrocPkg::RR_WORDS - 1)) begin
               wordIdx <= '0;
               if (chipIdx == lastChip) begin
                  lastWord <= 1'b1;
               end else begin
                  chipIdx <= chipIdx + 3'd1;
               end
            end else begin
               wordIdx <= wordIdx + 2'd1;
            end
         end else if (!bus.req && !bus.ack) begin
            if (lastWord) begin
               busy <= 1'b0;             // Frame complete
            end else begin
               bus.req <= 1'b1;
            end
         end
      end
   end

endmodule

//--- srArbiter.sv
`timescale 1ns/10ps

module srArbiter (
   input  logic   Clk,
   input  logic   rstN,
   srBusIf.server scBus,
   srBusIf.server rrBus,
   srBusIf.client srBus
);
   logic locked;      // Grant held for a whole frame
   logic owner;       // 1 slow control, 0 read register
   logic lockNext;
   logic ownerNext;
   logic ownReq;      // Req of the granted loader
   logic ackDly;
   logic chkReq;      // Cycle after ack fell, req must be back

   assign ownReq = owner ? scBus.req : rrBus.req;

   always_comb begin
      lockNext  = locked;
      ownerNext = owner;
      if (!locked) begin
         if (scBus.req && scBus.first) begin          // Slow control wins a tie
            lockNext  = 1'b1;
            ownerNext = 1'b1;
         end else if (rrBus.req && rrBus.first) begin
            lockNext  = 1'b1;
            ownerNext = 1'b0;
         end
      end else if (chkReq && !ownReq) begin            // No follow-up word
         lockNext = 1'b0;
      end
   end

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         locked    <= 1'b0;
         owner     <= 1'b0;
         ackDly    <= 1'b0;
         chkReq    <= 1'b0;
         srBus.req <= 1'b0;
      end else begin
         locked    <= lockNext;
         owner     <= ownerNext;
         ackDly    <= srBus.ack;
         chkReq    <= ackDly && !srBus.ack;           // Falling edge of ack
         srBus.req <= lockNext && (ownerNext ? scBus.req : rrBus.req);   // One cycle late
      end
   end

   // Payload follows the owner, ack goes straight back
   assign srBus.sel   = owner ? scBus.sel : rrBus.sel;
   assign srBus.first = owner ? scBus.first : rrBus.first;
   assign srBus.data  = owner ? scBus.data : rrBus.data;
   assign scBus.ack   = locked && owner && srBus.ack;
   assign rrBus.ack   = locked && !owner && srBus.ack;

endmodule

//--- srShifter.sv
`timescale 1ns/10ps

module srShifter (
   input  logic   Clk,
   input  logic   rstN,
   srBusIf.server bus,
   output logic   srSelect,
   output logic   srRstB,
   output logic   srCk,
   output logic   srIn
);
   microrocPkg::srStateT state;
   microrocPkg::srWordT  shiftReg;   // MSB drives SR_IN
   logic [3:0]           cnt;        // Reset cycles, then bit count

   assign srIn = shiftReg[15];

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         state    <= microrocPkg::srIdle;
         shiftReg <= '0;
         cnt      <= '0;
         srSelect <= 1'b0;
         srRstB   <= 1'b1;
         srCk     <= 1'b0;
         bus.ack  <= 1'b0;
      end else begin
         case (state)
            microrocPkg::srIdle: begin
               if (bus.req) begin
                  shiftReg <= bus.data;
                  cnt      <= '0;
                  if (bus.first) begin
                     srSelect <= bus.sel;                 // Held for the frame
                     srRstB   <= 1'b0;
                     state    <= microrocPkg::srRegReset;
                  end else begin
                     state <= microrocPkg::srShift;
                  end
               end
            end
            microrocPkg::srRegReset: begin
               if (cnt == 4'(microrocPkg::SR_RST_CYCLES - 1)) begin
                  srRstB <= 1'b1;
                  cnt    <= '0;
                  state  <= microrocPkg::srShift;
               end else begin
                  cnt <= cnt + 4'd1;
               end
            end
            microrocPkg::srShift: begin
               srCk <= ~srCk;                              // Clk divided by 2
               if (srCk) begin                             // Falling edge, next bit
                  shiftReg <= {shiftReg[14:0], 1'b0};
                  cnt      <= cnt + 4'd1;
                  if (cnt == 4'd15) begin
                     state <= microrocPkg::srAck;
                  end
               end
            end
            microrocPkg::srAck: begin
               if (!bus.ack) begin
                  bus.ack <= 1'b1;                         // Word done
               end else if (!bus.req) begin
                  bus.ack <= 1'b0;                         // Phase 4
                  state   <= microrocPkg::srIdle;
               end
            end
            default: state <= microrocPkg::srIdle;
         endcase
      end
   end

endmodule

//--- daqControl.sv
`timescale 1ns/10ps

module daqControl (
   input  logic                 Clk,
   input  logic                 rstN,
   input  logic                 acqStart,
   input  microrocPkg::acqTimeT acqTime,
   input  logic                 chipSatB,
   input  logic                 endReadout,
   output logic                 startAcq,
   output logic                 startReadout,
   output logic                 pwrOn,
   output logic                 acqDone
);
   microrocPkg::daqStateT state;
   microrocPkg::acqTimeT  cnt;   // Settle and acquisition timer

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         state        <= microrocPkg::daqIdle;
         cnt          <= '0;
         startAcq     <= 1'b0;
         startReadout <= 1'b0;
         pwrOn        <= 1'b0;
         acqDone      <= 1'b0;
      end else begin
         acqDone <= 1'b0;                                // Single-cycle pulse
         case (state)
            microrocPkg::daqIdle: begin
               if (acqStart) begin
                  pwrOn <= 1'b1;                         // Power pulsing on
                  cnt   <= '0;
                  state <= microrocPkg::daqPowerUp;
               end
            end
            microrocPkg::daqPowerUp: begin
               if (cnt == microrocPkg::acqTimeT'(microrocPkg::PWR_SETTLE - 1)) begin
                  startAcq <= 1'b1;
                  cnt      <= '0;
                  state    <= microrocPkg::daqAcquire;
               end else begin
                  cnt <= cnt + 16'd1;
               end
            end
            microrocPkg::daqAcquire: begin
               if (cnt == acqTime - 16'd1 || !chipSatB) begin   // Timeout or chip full
                  startAcq <= 1'b0;
                  state    <= microrocPkg::daqReadout;
               end else begin
                  cnt <= cnt + 16'd1;
               end
            end
            microrocPkg::daqReadout: begin
               if (!startReadout) begin
                  startReadout <= 1'b1;                  // Cycle after START_ACQ falls
               end else if (endReadout) begin
                  startReadout <= 1'b0;
                  state        <= microrocPkg::daqPowerDown;
               end
            end
            microrocPkg::daqPowerDown: begin
               pwrOn   <= 1'b0;
               acqDone <= 1'b1;
               state   <= microrocPkg::daqIdle;
            end
            default: state <= microrocPkg::daqIdle;
         endcase
      end
   end

endmodule

//--- ramReadout.sv
`timescale 1ns/10ps

module ramReadout (
   input  logic                 Clk,
   input  logic                 rstN,
   input  logic                 doutB,
   input  logic                 transmitOnB,
   input  logic                 extFifoFull,
   output microrocPkg::ramWordT parallelData,
   output logic                 parallelDataEn,
   output logic                 dataLost
);
   microrocPkg::ramWordT shiftReg;   // Incoming bits, first bit ends as MSB
   microrocPkg::ramWordT holdBuf;    // One completed word
   logic [3:0]           bitCnt;
   logic                 pending;    // holdBuf not yet taken
   logic                 wordDone;   // 16th bit sampled this cycle

   assign wordDone     = !transmitOnB && (bitCnt == 4'd15);
   assign parallelData = holdBuf;

   always_ff @(posedge Clk) begin
      if (!transmitOnB) begin
         shiftReg <= {shiftReg[14:0], ~doutB};          // DOUTB is active low
      end
      if (wordDone && !pending) begin
         holdBuf <= {shiftReg[14:0], ~doutB};
      end
   end

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         bitCnt         <= '0;
         pending        <= 1'b0;
         parallelDataEn <= 1'b0;
         dataLost       <= 1'b0;
      end else begin
         bitCnt         <= transmitOnB ? 4'd0 : bitCnt + 4'd1;   // Realign per transfer
         parallelDataEn <= 1'b0;
         if (pending && !extFifoFull) begin
            parallelDataEn <= 1'b1;                    // Push to external FIFO
            pending        <= 1'b0;
         end
         if (wordDone) begin
            if (pending) begin
               dataLost <= 1'b1;                       // Sticky, new word dropped
            end else begin
               pending <= 1'b1;
            end
         end
      end
   end

endmodule

//--- microrocTop.sv
`timescale 1ns/10ps

module microrocTop (
   input  logic                 Clk,
   input  logic                 rstN,
   input  logic                 forceReset,
   input  logic                 startLoad,
   input  logic                 startRead,
   input  microrocPkg::chipCntT asicNum,
   input  logic [63:0]          scConfig,
   input  microrocPkg::chnT     probeChn,
   input  logic                 acqStart,
   input  microrocPkg::acqTimeT acqTime,
   input  logic                 CHIPSATB,
   input  logic                 END_READOUT,
   input  logic                 DOUTB,
   input  logic                 TRANSMITONB,
   input  logic                 extFifoFull,
   output logic                 SELECT,
   output logic                 SR_RSTB,
   output logic                 SR_CK,
   output logic                 SR_IN,
   output logic                 PWR_ON,
   output logic                 START_ACQ,
   output logic                 START_READOUT,
   output logic                 RESET_B,
   output logic                 configDone,
   output logic                 acqDone,
   output microrocPkg::ramWordT parallelData,
   output logic                 parallelDataEn,
   output logic                 dataLost
);
   logic daqRstN;   // Board reset or forced chip reset

   assign daqRstN = rstN & ~forceReset;
   assign RESET_B = daqRstN;   // Digital reset to the chip

   //////////////////////////////////////////////////
   // Serial register path
   srBusIf scBus ();
   srBusIf rrBus ();
   srBusIf srBus ();

   scLoader scLoader_inst (
      .Clk        (Clk),
      .rstN       (rstN),
      .startLoad  (startLoad),
      .asicNum    (asicNum),
      .scConfig   (scConfig),
      .configDone (configDone),
      .bus        (scBus.client)
   );

   rrLoader rrLoader_inst (
      .Clk       (Clk),
      .rstN      (rstN),
      .startRead (startRead),
      .asicNum   (asicNum),
      .probeChn  (probeChn),
      .bus       (rrBus.client)
   );

   srArbiter srArbiter_inst (
      .Clk   (Clk),
      .rstN  (rstN),
      .scBus (scBus.server),
      .rrBus (rrBus.server),
      .srBus (srBus.client)
   );

   srShifter srShifter_inst (
      .Clk      (Clk),
      .rstN     (rstN),
      .bus      (srBus.server),
      .srSelect (SELECT),
      .srRstB   (SR_RSTB),
      .srCk     (SR_CK),
      .srIn     (SR_IN)
   );

   //////////////////////////////////////////////////
   // Acquisition and RAM readout
   daqControl daqControl_inst (
      .Clk          (Clk),
      .rstN         (daqRstN),
      .acqStart     (acqStart),
      .acqTime      (acqTime),
      .chipSatB     (CHIPSATB),
      .endReadout   (END_READOUT),
      .startAcq     (START_ACQ),
      .startReadout (START_READOUT),
      .pwrOn        (PWR_ON),
      .acqDone      (acqDone)
   );

   ramReadout ramReadout_inst (
      .Clk            (Clk),
      .rstN           (daqRstN),
      .doutB          (DOUTB),
      .transmitOnB    (TRANSMITONB),
      .extFifoFull    (extFifoFull),
      .parallelData   (parallelData),
      .parallelDataEn (parallelDataEn),
      .dataLost       (dataLost)
   );

endmodule

//--- tbClkGen.sv
`timescale 1ns/10ps

module tbClkGen (
   output logic Clk,
   output logic rstN
);
   initial begin
      Clk = 1'b0;
      forever #10 Clk = ~Clk;            // 20 ns period
   end

   initial begin
      rstN = 1'b0;
      repeat (8) @(posedge Clk);          // Reset held for 8 cycles
      rstN <= 1'b1;
   end
endmodule

//--- microroc_chk.sv
`timescale 1ns/10ps

module microrocChk (
   input logic                 Clk,
   input logic                 rstN,
   input logic                 forceReset,
   input logic                 CHIPSATB,
   input logic                 END_READOUT,
   input microrocPkg::acqTimeT acqTime,
   input logic                 SELECT,
   input logic                 SR_RSTB,
   input logic                 SR_CK,
   input logic                 SR_IN,
   input logic                 PWR_ON,
   input logic                 START_ACQ,
   input logic                 START_READOUT,
   input logic                 RESET_B,
   input logic                 configDone,
   input logic                 parallelDataEn,
   input logic                 dataLost,
   input logic                 srReq,
   input logic                 srAck
);
   int                   failCount = 0;   // Failed assertions so far
   microrocPkg::acqTimeT acqLen;          // Cycles START_ACQ seen high

   always_ff @(posedge Clk or negedge rstN) begin
      if (!rstN) begin
         acqLen <= '0;
      end else begin
         acqLen <= START_ACQ ? acqLen + 16'd1 : '0;
      end
   end

   //////////////////////////////////////////////////
   // Idle values after reset and after a forced chip reset
   assert property (@(posedge Clk) $rose(rstN) |-> !SELECT && SR_RSTB && !SR_CK && !SR_IN
         && !PWR_ON && !START_ACQ && !START_READOUT && !parallelDataEn && !configDone
         && !dataLost && RESET_B)
      else begin
         failCount++;
         $error("Outputs not idle after reset");
      end
   assert property (@(posedge Clk) $fell(forceReset) && rstN |-> !PWR_ON && !START_ACQ
         && !START_READOUT && !parallelDataEn && !dataLost && RESET_B)
      else begin
         failCount++;
         $error("DAQ outputs not idle after forceReset");
      end

   //////////////////////////////////////////////////
   // Four-phase order on the shifter bus
   assert property (@(posedge Clk) disable iff (!rstN) $rose(srAck) |-> srReq)
      else begin
         failCount++;
         $error("ack rose without req");
      end
   assert property (@(posedge Clk) disable iff (!rstN) $fell(srReq) |-> srAck)
      else begin
         failCount++;
         $error("req dropped before ack");
      end
   assert property (@(posedge Clk) disable iff (!rstN) $rose(srReq) |-> !srAck)
      else begin
         failCount++;
         $error("req raised while ack still high");
      end

   //////////////////////////////////////////////////
   // Acquisition sequence
   assert property (@(posedge Clk) disable iff (!rstN || forceReset)
         $rose(PWR_ON) |-> !START_ACQ [*microrocPkg::PWR_SETTLE] ##1 START_ACQ)
      else begin
         failCount++;
         $error("START_ACQ not PWR_SETTLE cycles after PWR_ON");
      end
   assert property (@(posedge Clk) disable iff (!rstN || forceReset)
         $fell(START_ACQ) |-> acqLen == acqTime || !$past(CHIPSATB))
      else begin
         failCount++;
         $error("START_ACQ length differs from acqTime");
      end
   assert property (@(posedge Clk) disable iff (!rstN || forceReset)
         $fell(CHIPSATB) && START_ACQ |=> !START_ACQ)
      else begin
         failCount++;
         $error("START_ACQ kept after CHIPSATB fell");
      end
   assert property (@(posedge Clk) disable iff (!rstN || forceReset)
         $fell(START_ACQ) |=> $rose(START_READOUT))
      else begin
         failCount++;
         $error("START_READOUT late after START_ACQ");
      end
   assert property (@(posedge Clk) disable iff (!rstN || forceReset)
         START_READOUT && !END_READOUT |=> START_READOUT)
      else begin
         failCount++;
         $error("START_READOUT dropped before END_READOUT");
      end
   assert property (@(posedge Clk) disable iff (!rstN || forceReset)
         $fell(START_READOUT) |=> $fell(PWR_ON))
      else begin
         failCount++;
         $error("PWR_ON not off one cycle after readout");
      end
   assert property (@(posedge Clk) disable iff (!rstN || forceReset) dataLost |=> dataLost)
      else begin
         failCount++;
         $error("dataLost cleared without reset");
      end

endmodule

bind microrocTop microrocChk microrocChk_inst (.*, .srReq(srBus.req), .srAck(srBus.ack));

//--- microrocTb.sv
`timescale 1ns/10ps

module microrocTb;
   typedef enum {
      forResetDone, forConfigDone, forFrame, forBusIdle,
      forAcq, forReadout, forPowerOff, forRamWords
   } waitT;

   logic                 Clk, rstN, forceReset, startLoad, startRead;
   microrocPkg::chipCntT asicNum;
   logic [63:0]          scConfig;
   microrocPkg::chnT     probeChn;
   logic                 acqStart;
   microrocPkg::acqTimeT acqTime;
   logic                 CHIPSATB, END_READOUT, DOUTB, TRANSMITONB, extFifoFull;
   logic                 SELECT, SR_RSTB, SR_CK, SR_IN;
   logic                 PWR_ON, START_ACQ, START_READOUT, RESET_B;
   logic                 configDone, acqDone, parallelDataEn, dataLost;
   microrocPkg::ramWordT parallelData;

   int           errCnt = 0;
   logic [31:0]  lcgState = 32'd13144;    // LCG seed
   int           frameCnt = 0;            // Frames seen on the serial register
   logic         frameSel [0:7];
   int           frameLen [0:7];
   logic [255:0] frameBits [0:7];         // First bit ends up highest
   logic [15:0]  gotQ[$];                 // Words taken by the external FIFO
   logic [15:0]  expQ[$];
   int           needFrame, needLen, needCnt;

   tbClkGen tbClkGen_inst (.Clk(Clk), .rstN(rstN));

   microrocTop microrocTop_inst (.*);

   function automatic logic [15:0] nextRand();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState[31:16];              // Upper bits are the better ones
   endfunction

   task automatic checkValue(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
      if (got !== exp) begin
         errCnt++;
         $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic finishRun();
      int assertErrs;
      assertErrs = microrocTop_inst.microrocChk_inst.failCount;
      $display("Checks done: %0d value errors, %0d assertion errors", errCnt, assertErrs);
      if (errCnt == 0 && assertErrs == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   endtask

   task automatic timedOut(input string what);
      errCnt++;
      $display("Timeout at %0t ns while waiting for %s", $time, what);
      finishRun();
   endtask

   function automatic logic condMet(input waitT what);
      case (what)
         forResetDone:  return rstN;
         forConfigDone: return configDone;
         forFrame:      return frameCnt > needFrame && frameLen[needFrame] == needLen;
         forBusIdle:    return !microrocTop_inst.srArbiter_inst.locked;
         forAcq:        return START_ACQ;
         forReadout:    return START_READOUT;
         forPowerOff:   return !PWR_ON;
         forRamWords:   return gotQ.size() >= needCnt;
         default:       return 1'b0;
      endcase
   endfunction

   task automatic waitUntil(input waitT what, input int limit);
      int n;
      n = 0;
      while (!condMet(what) && n < limit) begin
         @(negedge Clk);
         n++;
      end
      if (!condMet(what)) timedOut(what.name());
   endtask

   //////////////////////////////////////////////////
   // Serial register model, one frame per SR_RSTB pulse
   always @(negedge SR_RSTB) begin
      if (frameCnt < 8) begin
         frameLen[frameCnt]  = 0;
         frameBits[frameCnt] = '0;
         frameCnt++;
      end
   end

   always @(posedge SR_CK) begin
      if (frameCnt == 0) begin
         errCnt++;
         $display("SR_CK toggled before any SR_RSTB pulse at %0t ns", $time);
      end else begin
         if (frameLen[frameCnt - 1] == 0) begin
            frameSel[frameCnt - 1] = SELECT;   // Frame tag
         end else begin
            checkValue("SELECT", SELECT, frameSel[frameCnt - 1]);
         end
         frameBits[frameCnt - 1] = {frameBits[frameCnt - 1][254:0], SR_IN};
         frameLen[frameCnt - 1]++;
      end
   end

   always @(negedge Clk) begin
      if (rstN && parallelDataEn) gotQ.push_back(parallelData);
   end

   //////////////////////////////////////////////////
   // Chip model
   task automatic sendRamWord(input logic [15:0] w);
      int i;
      for (i = 15; i >= 0; i--) begin
         @(posedge Clk);
         TRANSMITONB <= 1'b0;
         DOUTB       <= ~w[i];              // Active low, MSB first
      end
      @(posedge Clk);
      TRANSMITONB <= 1'b1;
   endtask

   task automatic runAcquisition(input int satAfter);
      @(posedge Clk);
      acqStart <= 1'b1;
      @(posedge Clk);
      acqStart <= 1'b0;
      waitUntil(forAcq, 50);
      if (satAfter > 0) begin
         repeat (satAfter) @(posedge Clk);
         CHIPSATB <= 1'b0;                  // Chip memory full
      end
      waitUntil(forReadout, 100);
      repeat (6) @(posedge Clk);             // RAM transfer time
      END_READOUT <= 1'b1;
      CHIPSATB    <= 1'b1;
      @(posedge Clk);
      END_READOUT <= 1'b0;
      waitUntil(forPowerOff, 20);
      checkValue("acqDone", acqDone, 1);     // Pulses with power off
   endtask

   initial begin
      int          c, i;
      logic [15:0] w;
      forceReset  = 1'b0;
      startLoad   = 1'b0;
      startRead   = 1'b0;
      asicNum     = '0;
      scConfig    = '0;
      probeChn    = '0;
      acqStart    = 1'b0;
      acqTime     = 16'd20;
      CHIPSATB    = 1'b1;
      END_READOUT = 1'b0;
      DOUTB       = 1'b1;
      TRANSMITONB = 1'b1;
      extFifoFull = 1'b0;
      waitUntil(forResetDone, 20);

      // Slow control over three chips
      @(posedge Clk);
      asicNum   <= 3'd3;
      scConfig  <= {nextRand(), nextRand(), nextRand(), nextRand()};
      startLoad <= 1'b1;
      @(posedge Clk);
      startLoad <= 1'b0;
      waitUntil(forConfigDone, 2000);
      checkValue("frame length at configDone", frameLen[0], 192);
      checkValue("SELECT of slow-control frame", frameSel[0], 1);
      for (c = 0; c < 3; c++) begin
         checkValue("slow-control image", frameBits[0][c*64 +: 64], scConfig);
      end

      // Read register, channel 37 on two chips
      @(posedge Clk);
      asicNum   <= 3'd2;
      probeChn  <= 6'd37;
      startRead <= 1'b1;
      @(posedge Clk);
      startRead <= 1'b0;
      needFrame = 1;
      needLen   = 128;
      waitUntil(forFrame, 1000);
      waitUntil(forBusIdle, 50);
      checkValue("read-register frame length", frameLen[1], 128);
      checkValue("SELECT of read-register frame", frameSel[1], 0);
      for (c = 0; c < 2; c++) begin
         checkValue("read-register image", frameBits[1][c*64 +: 64], 64'h1 << 37);
      end

      // Both loaders at once, slow control first
      @(posedge Clk);
      asicNum   <= 3'd1;
      startLoad <= 1'b1;
      startRead <= 1'b1;
      @(posedge Clk);
      startLoad <= 1'b0;
      startRead <= 1'b0;
      needFrame = 3;
      needLen   = 64;
      waitUntil(forFrame, 1000);
      waitUntil(forBusIdle, 50);
      checkValue("frames seen", frameCnt, 4);
      checkValue("first frame length", frameLen[2], 64);
      checkValue("first frame SELECT", frameSel[2], 1);
      checkValue("first frame image", frameBits[2][63:0], scConfig);
      checkValue("second frame length", frameLen[3], 64);
      checkValue("second frame SELECT", frameSel[3], 0);
      checkValue("second frame image", frameBits[3][63:0], 64'h1 << 37);

      // Full acquisition, then one cut short by CHIPSATB
      runAcquisition(0);
      runAcquisition(5);

      // RAM readout, free flow, one held word, one lost word
      for (i = 0; i < 4; i++) begin
         w = nextRand();
         expQ.push_back(w);
         sendRamWord(w);
      end
      needCnt = 4;
      waitUntil(forRamWords, 20);
      @(posedge Clk);
      extFifoFull <= 1'b1;
      w = nextRand();
      expQ.push_back(w);
      sendRamWord(w);
      repeat (4) @(posedge Clk);
      checkValue("words taken while extFifoFull", gotQ.size(), 4);
      extFifoFull <= 1'b0;
      needCnt = 5;
      waitUntil(forRamWords, 20);
      @(posedge Clk);
      extFifoFull <= 1'b1;
      w = nextRand();
      expQ.push_back(w);
      sendRamWord(w);
      sendRamWord(nextRand());               // Dropped, buffer still full
      @(negedge Clk);
      checkValue("dataLost", dataLost, 1);
      @(posedge Clk);
      extFifoFull <= 1'b0;
      needCnt = 6;
      waitUntil(forRamWords, 20);
      checkValue("RAM word count", gotQ.size(), expQ.size());
      for (i = 0; i < expQ.size() && i < gotQ.size(); i++) begin
         checkValue("parallelData", gotQ[i], expQ[i]);
      end

      // Forced chip reset in the middle of an acquisition
      @(posedge Clk);
      acqStart <= 1'b1;
      @(posedge Clk);
      acqStart <= 1'b0;
      waitUntil(forAcq, 50);
      @(posedge Clk);
      forceReset <= 1'b1;
      repeat (3) @(posedge Clk);
      forceReset <= 1'b0;
      @(negedge Clk);
      checkValue("dataLost after forceReset", dataLost, 0);
      checkValue("PWR_ON after forceReset", PWR_ON, 0);
      repeat (5) @(posedge Clk);
      finishRun();
   end
endmodule

//--- sim.f
microrocPkg.sv
srBusIf.sv
scLoader.sv
rrLoader.sv
srArbiter.sv
srShifter.sv
daqControl.sv
ramReadout.sv
microrocTop.sv
tbClkGen.sv
microroc_chk.sv
microrocTb.sv

//--- Bender.yml
package:
  name: microroc

sources:
  - microrocPkg.sv
  - srBusIf.sv
  - scLoader.sv
  - rrLoader.sv
  - srArbiter.sv
  - srShifter.sv
  - daqControl.sv
  - ramReadout.sv
  - microrocTop.sv
  - target: simulation
    files:
      - tbClkGen.sv
      - microroc_chk.sv
      - microrocTb.sv
